// ==== sim.f ====
+incdir+src
src/mul_accel_pkg.sv
src/sync_fifo.sv
src/mul_shift_add_pipe.sv
src/mul_dispatch.sv
src/axil_mul_regs.sv
src/mul_accel_top.sv
sim/mul_accel_properties.sv
sim/mul_accel_tb.sv

// ==== Bender.yml ====
package:
  name: mul_accel

sources:
  - include_dirs:
      - src
    files:
      - src/mul_accel_pkg.sv
      - src/sync_fifo.sv
      - src/mul_shift_add_pipe.sv
      - src/mul_dispatch.sv
      - src/axil_mul_regs.sv
      - src/mul_accel_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/mul_accel_properties.sv
      - sim/mul_accel_tb.sv

// ==== sim/mul_accel_tb.sv ====
`timescale 1ns/1ns
`include "mul_accel_config.svh"

module mul_accel_tb;
  import mul_accel_pkg::*;

  localparam int         TIMEOUT = 300; // Cycles for a handshake and STATUS reads for a poll.
  localparam logic [1:0] OKAY    = 2'b00;
  localparam logic [1:0] SLVERR  = 2'b10;

  logic         clk;
  logic         rst_n;
  axil_wr_req_t wr_req;
  axil_wr_rsp_t wr_rsp;
  axil_rd_req_t rd_req;
  axil_rd_rsp_t rd_rsp;
  int           seed;
  int           test_errors;
  int           tests_run;
  int           tests_failed;
  logic [31:0]  expected_q [$]; // Products in write order.

  mul_accel_top dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_req (wr_req),
    .wr_rsp (wr_rsp),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic timed_out(input string what);
    $display("Timed out waiting for %s.", what);
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("%-16s %s, %0d errors", name, (test_errors == 0) ? "passed" : "failed",
             test_errors);
    test_errors = 0;
  endtask

  // ================================================
  // AXI4-Lite bus tasks driven on the falling edge.
  // ================================================
  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int t;
    @(negedge clk);
    wr_req.awaddr  = addr;
    wr_req.wdata   = data;
    wr_req.awvalid = 1'b1;
    wr_req.wvalid  = 1'b1;
    #1;
    for (t = 0; t < TIMEOUT && !wr_rsp.awready; t++) begin // Stalls while the FIFO is full.
      @(negedge clk);
      #1;
    end
    if (!wr_rsp.awready) begin
      timed_out("AWREADY and WREADY");
    end else begin
      check_eq("WREADY with AWREADY", 1, wr_rsp.wready); // Both channels go in one cycle.
    end
    @(negedge clk);
    wr_req.awvalid = 1'b0;
    wr_req.wvalid  = 1'b0;
    wr_req.bready  = 1'b1;
    #1;
    for (t = 0; t < TIMEOUT && !wr_rsp.bvalid; t++) begin
      @(negedge clk);
      #1;
    end
    if (!wr_rsp.bvalid) timed_out("BVALID");
    resp = wr_rsp.bresp;
    @(negedge clk);
    wr_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int t;
    @(negedge clk);
    rd_req.araddr  = addr;
    rd_req.arvalid = 1'b1;
    #1;
    for (t = 0; t < TIMEOUT && !rd_rsp.arready; t++) begin
      @(negedge clk);
      #1;
    end
    if (!rd_rsp.arready) timed_out("ARREADY");
    @(negedge clk);
    rd_req.arvalid = 1'b0;
    rd_req.rready  = 1'b1;
    #1;
    for (t = 0; t < TIMEOUT && !rd_rsp.rvalid; t++) begin
      @(negedge clk);
      #1;
    end
    if (!rd_rsp.rvalid) timed_out("RVALID");
    data = rd_rsp.rdata;
    resp = rd_rsp.rresp;
    @(negedge clk);
    rd_req.rready = 1'b0;
  endtask

  task automatic poll_status(input int bit_idx, input string what);
    logic [31:0] status;
    logic [1:0]  resp;
    int          t;
    status = '0;
    for (t = 0; t < TIMEOUT && !status[bit_idx]; t++) begin
      axil_read(`REG_STATUS, status, resp);
    end
    if (!status[bit_idx]) timed_out(what);
  endtask

  // ================================================
  // Operand and result helpers.
  // ================================================
  task automatic write_pair(input logic [7:0] a, input logic [7:0] b);
    logic [1:0] resp;
    expected_q.push_back(32'(a) * 32'(b));
    axil_write(`REG_OPERAND, {16'h0, a, b}, resp);
    check_eq("operand write resp", OKAY, resp);
  endtask

  task automatic write_random(input int n);
    logic [7:0] a;
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      a = 8'($random(seed));
      b = 8'($random(seed));
      write_pair(a, b);
    end
  endtask

  task automatic read_expected(input int n, input string name);
    logic [31:0] data;
    logic [1:0]  resp;
    for (int i = 0; i < n; i++) begin
      poll_status(0, "a result in STATUS");
      axil_read(`REG_RESULT, data, resp);
      check_eq(name, expected_q.pop_front(), data);
      check_eq({name, " resp"}, OKAY, resp);
    end
  endtask

  initial begin
    logic [31:0] status;
    logic [31:0] rdata;
    logic [1:0]  resp;

    seed         = 32'h2bd4;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    wr_req       = '0;
    rd_req       = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_eq("reset handshakes", 0, {wr_rsp.awready, wr_rsp.wready, wr_rsp.bvalid,
                                     rd_rsp.arready, rd_rsp.rvalid});
    axil_read(`REG_STATUS, status, resp);
    check_eq("reset status", 0, status);
    finish_test("reset");

    write_pair(8'd0, 8'd173);
    read_expected(1, "0 x 173");
    write_pair(8'd1, 8'd94);
    read_expected(1, "1 x 94");
    write_pair(8'd255, 8'd255);
    read_expected(1, "255 x 255");
    write_pair(8'd128, 8'd2);
    read_expected(1, "128 x 2");
    finish_test("directed");

    // Reads start only once the operand FIFO pushes back.
    fork
      write_random(20);
      begin
        poll_status(1, "the operand FIFO to fill");
        read_expected(20, "burst product");
      end
    join
    finish_test("burst");

    write_random(5);
    status = '0;
    for (int t = 0; t < TIMEOUT && status[11:8] != 4'd5; t++) begin
      axil_read(`REG_STATUS, status, resp);
    end
    check_eq("result count", 5, status[11:8]);
    check_eq("status not empty", 1, status[0]);
    read_expected(5, "count product");
    finish_test("result count");

    axil_read(`REG_RESULT, rdata, resp);
    check_eq("empty result data", 0, rdata);
    check_eq("empty result resp", SLVERR, resp);
    axil_read(4'hC, rdata, resp);
    check_eq("unmapped read resp", SLVERR, resp);
    axil_write(4'hC, 32'h0000_1234, resp);
    check_eq("unmapped write resp", SLVERR, resp);
    write_pair(8'd3, 8'd5);
    poll_status(0, "a result before the STATUS write");
    axil_write(`REG_STATUS, 32'h0, resp);
    check_eq("status write resp", SLVERR, resp);
    axil_read(`REG_STATUS, status, resp);
    check_eq("count after status write", 1, status[11:8]);
    read_expected(1, "3 x 5");
    finish_test("error responses");

    $display("%0d tests, %0d failed, %0d assertion failures", tests_run, tests_failed,
             dut.u_props.failures);
    if (tests_failed == 0 && dut.u_props.failures == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim/mul_accel_properties.sv ====
`timescale 1ns/1ns
`include "mul_accel_config.svh"

module mul_accel_properties (
  input logic                             clk,
  input logic                             rst_n,
  input mul_accel_pkg::axil_wr_req_t      wr_req,
  input mul_accel_pkg::axil_wr_rsp_t      wr_rsp,
  input mul_accel_pkg::axil_rd_req_t      rd_req,
  input mul_accel_pkg::axil_rd_rsp_t      rd_rsp,
  input logic                             op_push,
  input logic                             op_full,
  input logic                             op_pop,
  input logic                             op_empty,
  input mul_accel_pkg::operand_pair_t     op_head,
  input logic                             res_push,
  input mul_accel_pkg::product_t          res_push_data,
  input logic                             res_pop,
  input logic                             res_empty,
  input logic [$clog2(`RES_FIFO_DEPTH):0] res_count,
  input logic [$clog2(`RES_FIFO_DEPTH):0] credit
);
  import mul_accel_pkg::*;

  int failures = 0; // Summed into the closing report.

  // A product leaves the pipeline exactly MUL_PIPE_LAT cycles after its issue.
  pipe_product: assert property (@(posedge clk) disable iff (!rst_n)
    res_push |-> $past(op_pop, `MUL_PIPE_LAT) &&
                 res_push_data == product_t'($past(op_head.a, `MUL_PIPE_LAT)) *
                                  product_t'($past(op_head.b, `MUL_PIPE_LAT)))
    else begin
      $error("Pipeline product does not match the operands issued earlier.");
      failures++;
    end

  fifo_bounds: assert property (@(posedge clk) disable iff (!rst_n)
    !(op_push && op_full) && !(op_pop && op_empty) &&
    !(res_push && res_count == `RES_FIFO_DEPTH) && !(res_pop && res_empty))
    else begin
      $error("FIFO pushed while full or popped while empty.");
      failures++;
    end

  bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
    wr_rsp.bvalid && !wr_req.bready |=> wr_rsp.bvalid && $stable(wr_rsp.bresp))
    else begin
      $error("BVALID or BRESP changed before BREADY.");
      failures++;
    end

  rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
    rd_rsp.rvalid && !rd_req.rready |=>
      rd_rsp.rvalid && $stable(rd_rsp.rdata) && $stable(rd_rsp.rresp))
    else begin
      $error("RVALID or read data changed before RREADY.");
      failures++;
    end

  credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credit <= `RES_FIFO_DEPTH)
    else begin
      $error("Dispatch credit above the result FIFO depth.");
      failures++;
    end

endmodule

bind mul_accel_top mul_accel_properties u_props (
  .*,
  .credit (u_dispatch.credit)
);

// ==== src/mul_accel_top.sv ====
`timescale 1ns/1ns
`include "mul_accel_config.svh"

module mul_accel_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  mul_accel_pkg::axil_wr_req_t wr_req,
  output mul_accel_pkg::axil_wr_rsp_t wr_rsp,
  input  mul_accel_pkg::axil_rd_req_t rd_req,
  output mul_accel_pkg::axil_rd_rsp_t rd_rsp
);
  import mul_accel_pkg::*;

  localparam int RES_CNT_W = $clog2(`RES_FIFO_DEPTH) + 1;

  // Operand side.
  operand_pair_t        op_push_data;
  operand_pair_t        op_head;
  logic                 op_push;
  logic                 op_pop;
  logic                 op_full;
  logic                 op_empty;

  // Result side.
  product_t             res_push_data;
  product_t             res_head;
  logic                 res_push;
  logic                 res_pop;
  logic                 res_empty;
  logic [RES_CNT_W-1:0] res_count;

  axil_mul_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_req    (wr_req),
    .wr_rsp    (wr_rsp),
    .rd_req    (rd_req),
    .rd_rsp    (rd_rsp),
    .op_push   (op_push),
    .op_data   (op_push_data),
    .op_full   (op_full),
    .res_pop   (res_pop),
    .res_data  (res_head),
    .res_empty (res_empty),
    .res_count (res_count)
  );

  sync_fifo #(
    .item_t (operand_pair_t),
    .DEPTH  (`OP_FIFO_DEPTH)
  ) op_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (op_push),
    .push_data (op_push_data),
    .pop       (op_pop),
    .pop_data  (op_head),
    .full      (op_full),
    .empty     (op_empty),
    .count     ()
  );

  // Never full on a push, the dispatch credits see to that.
  sync_fifo #(
    .item_t (product_t),
    .DEPTH  (`RES_FIFO_DEPTH)
  ) res_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (res_push),
    .push_data (res_push_data),
    .pop       (res_pop),
    .pop_data  (res_head),
    .full      (),
    .empty     (res_empty),
    .count     (res_count)
  );

  mul_dispatch u_dispatch (
    .clk           (clk),
    .rst_n         (rst_n),
    .op_data       (op_head),
    .op_empty      (op_empty),
    .op_pop        (op_pop),
    .res_push      (res_push),
    .res_push_data (res_push_data),
    .res_pop       (res_pop)
  );

endmodule

// ==== src/axil_mul_regs.sv ====
`timescale 1ns/1ns
`include "mul_accel_config.svh"

module axil_mul_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  input  mul_accel_pkg::axil_wr_req_t  wr_req,
  output mul_accel_pkg::axil_wr_rsp_t  wr_rsp,
  input  mul_accel_pkg::axil_rd_req_t  rd_req,
  output mul_accel_pkg::axil_rd_rsp_t  rd_rsp,
  output logic                         op_push,
  output mul_accel_pkg::operand_pair_t op_data,
  input  logic                         op_full,
  output logic                         res_pop,
  input  mul_accel_pkg::product_t      res_data,
  input  logic                         res_empty,
  input  logic [$clog2(`RES_FIFO_DEPTH):0] res_count
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam int         W           = `MUL_OP_W;

  logic        wr_go;
  logic        wr_is_operand;
  logic        bvalid;
  logic [1:0]  bresp;
  logic        rd_go;
  logic        rvalid;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic [31:0] rdata_nxt;
  logic [1:0]  rresp_nxt;

  // ================================================
  // Write channel.
  // ================================================

  // AW and W are taken as a pair, only with room in the operand FIFO.
  assign wr_go = wr_req.awvalid && wr_req.wvalid && !op_full && !bvalid;

  assign wr_is_operand = (wr_req.awaddr == `REG_OPERAND);
  assign op_push       = wr_go && wr_is_operand;
  assign op_data       = '{a: wr_req.wdata[2*W-1:W], b: wr_req.wdata[W-1:0]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
    end else if (wr_go) begin
      bvalid <= 1'b1;
    end else if (wr_req.bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_go) begin
      bresp <= wr_is_operand ? RESP_OKAY : RESP_SLVERR; // RESULT and STATUS are read-only.
    end
  end

  assign wr_rsp = '{awready: wr_go, wready: wr_go, bvalid: bvalid, bresp: bresp};

  // ================================================
  // Read channel.
  // ================================================
  assign rd_go = rd_req.arvalid && !rvalid;

  always_comb begin
    rdata_nxt = '0;
    rresp_nxt = RESP_SLVERR;
    res_pop   = 1'b0;
    case (rd_req.araddr)
      `REG_RESULT: begin
        // Empty queue answers 0 with an error.
        if (!res_empty) begin
          rdata_nxt = 32'(res_data);
          rresp_nxt = RESP_OKAY;
          res_pop   = rd_go;
        end
      end
      `REG_STATUS: begin
        rdata_nxt[0]                      = !res_empty;
        rdata_nxt[1]                      = op_full;
        rdata_nxt[8 +: $bits(res_count)]  = res_count;
        rresp_nxt                         = RESP_OKAY;
      end
      default: begin
        rresp_nxt = RESP_SLVERR; // Unmapped.
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_go) begin
      rvalid <= 1'b1;
    end else if (rd_req.rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_go) begin
      rdata <= rdata_nxt;
      rresp <= rresp_nxt;
    end
  end

  assign rd_rsp = '{arready: rd_go, rvalid: rvalid, rdata: rdata, rresp: rresp};

endmodule

// ==== src/mul_dispatch.sv ====
`timescale 1ns/1ns
`include "mul_accel_config.svh"

module mul_dispatch (
  input  logic                         clk,
  input  logic                         rst_n,
  input  mul_accel_pkg::operand_pair_t op_data,
  input  logic                         op_empty,
  output logic                         op_pop,
  output logic                         res_push,
  output mul_accel_pkg::product_t      res_push_data,
  input  logic                         res_pop
);

  localparam int CREDIT_W = $clog2(`RES_FIFO_DEPTH) + 1;

  logic [CREDIT_W-1:0] credit; // Free result slots not yet claimed.
  logic                issue;

  // One pair per cycle while a result slot is reserved for it.
  assign issue  = !op_empty && (credit != '0);
  assign op_pop = issue;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit <= CREDIT_W'(`RES_FIFO_DEPTH);
    end else begin
      case ({issue, res_pop})
        2'b10:   credit <= credit - 1'b1;
        2'b01:   credit <= credit + 1'b1; // Software freed a slot.
        default: credit <= credit;
      endcase
    end
  end

  // Products go straight to the result FIFO, room is already reserved.
  mul_shift_add_pipe u_pipe (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (issue),
    .in_ops      (op_data),
    .out_valid   (res_push),
    .out_product (res_push_data)
  );

endmodule

// ==== src/mul_shift_add_pipe.sv ====
`timescale 1ns/1ns
`include "mul_accel_config.svh"

module mul_shift_add_pipe (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         in_valid,
  input  mul_accel_pkg::operand_pair_t in_ops,
  output logic                         out_valid,
  output mul_accel_pkg::product_t      out_product
);
  import mul_accel_pkg::*;

  localparam int N_STAGES = `MUL_OP_W;

  // Operands ride along with the running sum.
  typedef struct packed {
    operand_pair_t ops;
    product_t      sum;
  } stage_t;

  stage_t            stage [N_STAGES+1];
  logic [N_STAGES:0] stage_vld;

  // Shifted copy of a when bit k of b is set.
  function automatic product_t partial_product(operand_pair_t ops, int k);
    return ops.b[k] ? (product_t'(ops.a) << k) : '0;
  endfunction

  // ================================================
  // Valid chain.
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_vld <= '0;
      out_valid <= 1'b0;
    end else begin
      stage_vld <= {stage_vld[N_STAGES-1:0], in_valid};
      out_valid <= stage_vld[N_STAGES];
    end
  end

  // ================================================
  // Data path, one partial product per stage.
  // ================================================
  always_ff @(posedge clk) begin
    if (in_valid) begin
      stage[0].ops <= in_ops; // Stage 0 only captures.
      stage[0].sum <= '0;
    end
    for (int k = 0; k < N_STAGES; k++) begin
      if (stage_vld[k]) begin
        stage[k+1].ops <= stage[k].ops;
        stage[k+1].sum <= stage[k].sum + partial_product(stage[k].ops, k);
      end
    end
    if (stage_vld[N_STAGES]) begin
      out_product <= stage[N_STAGES].sum; // Held between results.
    end
  end

endmodule

// ==== src/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
  parameter type       item_t = logic [7:0],
  parameter int        DEPTH  = 4,
  localparam int       PTR_W  = $clog2(DEPTH)
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         push,
  input  item_t        push_data,
  input  logic         pop,
  output item_t        pop_data,
  output logic         full,
  output logic         empty,
  output logic [PTR_W:0] count
);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign full  = (count == (PTR_W+1)'(DEPTH));
  assign empty = (count == '0);

  // Overflow and underflow requests are dropped.
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign pop_data = mem[rd_ptr]; // Head is visible without a pop.

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // ================================================
  // Pointers and occupancy.
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1; // Wraps, depth is a power of two.
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== src/mul_accel_pkg.sv ====
`include "mul_accel_config.svh"

package mul_accel_pkg;

  // One multiply request.
  typedef struct packed {
    logic [`MUL_OP_W-1:0] a;
    logic [`MUL_OP_W-1:0] b;
  } operand_pair_t;

  typedef logic [2*`MUL_OP_W-1:0] product_t;

  // ================================================
  // AXI4-Lite channels, split by direction.
  // ================================================
  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] awaddr;
    logic                    awvalid;
    logic [31:0]             wdata;
    logic                    wvalid;
    logic                    bready;
  } axil_wr_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
  } axil_wr_rsp_t;

  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] araddr;
    logic                    arvalid;
    logic                    rready;
  } axil_rd_req_t;

  typedef struct packed {
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rd_rsp_t;

endpackage

// ==== src/mul_accel_config.svh ====
`ifndef MUL_ACCEL_CONFIG_SVH
`define MUL_ACCEL_CONFIG_SVH

// Datapath.
`define MUL_OP_W        8
`define MUL_PIPE_LAT    10

// Queue sizes, both powers of two.
`define OP_FIFO_DEPTH   4
`define RES_FIFO_DEPTH  8

// AXI4-Lite register map.
`define AXIL_ADDR_W     4
`define REG_OPERAND     4'h0
`define REG_RESULT      4'h4
`define REG_STATUS      4'h8

`endif
